// ==== src/exec_pkg.sv ====
// Data widths, instruction field positions, opcode values and ALU operation codes
package exec_pkg;

	localparam int xlen       = 32;
	localparam int reg_addr_w = 5;
	localparam int num_regs   = 16;   // Registers 0 to 15, 0 reads as zero
	localparam int imm_w      = 13;
	localparam int op_w       = 4;
	localparam int alu_op_w   = 3;

	// Instruction field positions
	localparam int op_hi  = 31;
	localparam int op_lo  = 28;
	localparam int rd_hi  = 27;
	localparam int rd_lo  = 23;
	localparam int rs_hi  = 22;
	localparam int rs_lo  = 18;
	localparam int rt_hi  = 17;
	localparam int rt_lo  = 13;
	localparam int imm_hi = 12;
	localparam int imm_lo = 0;

	localparam logic [op_w-1:0] op_add  = 4'd0;
	localparam logic [op_w-1:0] op_sub  = 4'd1;
	localparam logic [op_w-1:0] op_and  = 4'd2;
	localparam logic [op_w-1:0] op_or   = 4'd3;
	localparam logic [op_w-1:0] op_xor  = 4'd4;
	localparam logic [op_w-1:0] op_slt  = 4'd5;   // Signed compare
	localparam logic [op_w-1:0] op_addi = 4'd6;
	localparam logic [op_w-1:0] op_lui  = 4'd7;   // Opcodes 8 to 15 are illegal

	localparam logic [alu_op_w-1:0] alu_add = 3'd0;
	localparam logic [alu_op_w-1:0] alu_sub = 3'd1;
	localparam logic [alu_op_w-1:0] alu_and = 3'd2;
	localparam logic [alu_op_w-1:0] alu_or  = 3'd3;
	localparam logic [alu_op_w-1:0] alu_xor = 3'd4;
	localparam logic [alu_op_w-1:0] alu_slt = 3'd5;
	localparam logic [alu_op_w-1:0] alu_lui = 3'd6;

endpackage

// ==== src/regfile.sv ====
// Register file with two read ports, one write port and a debug read port
`timescale 1ns/1ns

module regfile (
	input  logic clk,
	input  logic rst,
	input  logic [exec_pkg::reg_addr_w-1:0] raddr_a,
	input  logic [exec_pkg::reg_addr_w-1:0] raddr_b,
	input  logic [exec_pkg::reg_addr_w-1:0] waddr,
	input  logic [exec_pkg::xlen-1:0] wdata,
	input  logic we,
	output logic [exec_pkg::xlen-1:0] rdata_a,
	output logic [exec_pkg::xlen-1:0] rdata_b,
	input  logic [exec_pkg::reg_addr_w-1:0] which_reg,
	output logic [exec_pkg::xlen-1:0] reg_content
);

	// Register 0 is not stored
	logic [exec_pkg::xlen-1:0] regs [1:exec_pkg::num_regs-1];

	function automatic logic [exec_pkg::xlen-1:0] read_reg(
		input logic [exec_pkg::reg_addr_w-1:0] addr
	);
		logic [exec_pkg::xlen-1:0] val;
		val = '0;
		if (addr != '0 && 32'(addr) < exec_pkg::num_regs) begin
			val = regs[addr[exec_pkg::reg_addr_w-2:0]];
		end
		return val;
	endfunction

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 1; i < exec_pkg::num_regs; i++) begin
				regs[i] <= '0;
			end
		end else if (we && waddr != '0 && 32'(waddr) < exec_pkg::num_regs) begin
			regs[waddr[exec_pkg::reg_addr_w-2:0]] <= wdata;   // Addresses 16 and up fall through
		end
	end

	// All three read ports are combinational
	always_comb begin
		rdata_a     = read_reg(raddr_a);
		rdata_b     = read_reg(raddr_b);
		reg_content = read_reg(which_reg);
	end

endmodule

// ==== src/instr_decoder.sv ====
// Instruction field extraction, immediate sign extension and ALU operation select
`timescale 1ns/1ns

module instr_decoder (
	input  logic [exec_pkg::xlen-1:0] instr,
	output logic [exec_pkg::reg_addr_w-1:0] rs_addr,
	output logic [exec_pkg::reg_addr_w-1:0] rt_addr,
	output logic [exec_pkg::reg_addr_w-1:0] rd_addr,
	output logic [exec_pkg::alu_op_w-1:0] alu_op,
	output logic use_imm,
	output logic legal,
	output logic [exec_pkg::xlen-1:0] imm_ext
);

	logic [exec_pkg::op_w-1:0] opcode;
	logic [exec_pkg::imm_w-1:0] imm;

	assign opcode  = instr[exec_pkg::op_hi:exec_pkg::op_lo];
	assign rd_addr = instr[exec_pkg::rd_hi:exec_pkg::rd_lo];
	assign rs_addr = instr[exec_pkg::rs_hi:exec_pkg::rs_lo];
	assign rt_addr = instr[exec_pkg::rt_hi:exec_pkg::rt_lo];
	assign imm     = instr[exec_pkg::imm_hi:exec_pkg::imm_lo];

	assign imm_ext = {{(exec_pkg::xlen - exec_pkg::imm_w){imm[exec_pkg::imm_w-1]}}, imm};

	always_comb begin
		alu_op  = exec_pkg::alu_add;
		use_imm = 1'b0;
		legal   = 1'b1;
		case (opcode)
			exec_pkg::op_add: alu_op = exec_pkg::alu_add;
			exec_pkg::op_sub: alu_op = exec_pkg::alu_sub;
			exec_pkg::op_and: alu_op = exec_pkg::alu_and;
			exec_pkg::op_or:  alu_op = exec_pkg::alu_or;
			exec_pkg::op_xor: alu_op = exec_pkg::alu_xor;
			exec_pkg::op_slt: alu_op = exec_pkg::alu_slt;
			exec_pkg::op_addi: begin
				alu_op  = exec_pkg::alu_add;
				use_imm = 1'b1;
			end
			exec_pkg::op_lui: begin
				alu_op  = exec_pkg::alu_lui;
				use_imm = 1'b1;
			end
			default: legal = 1'b0;   // Upper half of opcode space
		endcase
	end

endmodule

// ==== src/alu.sv ====
// 32-bit arithmetic and logic unit with immediate operand select
`timescale 1ns/1ns

module alu (
	input  logic [exec_pkg::xlen-1:0] a,
	input  logic [exec_pkg::xlen-1:0] b,
	input  logic [exec_pkg::xlen-1:0] imm_ext,
	input  logic use_imm,
	input  logic [exec_pkg::alu_op_w-1:0] alu_op,
	output logic [exec_pkg::xlen-1:0] y
);

	logic [exec_pkg::xlen-1:0] op_b;
	logic lt;

	assign op_b = use_imm ? imm_ext : b;
	assign lt   = $signed(a) < $signed(op_b);

	// Add and sub wrap at 32 bits
	always_comb begin
		case (alu_op)
			exec_pkg::alu_add: y = a + op_b;
			exec_pkg::alu_sub: y = a - op_b;
			exec_pkg::alu_and: y = a & op_b;
			exec_pkg::alu_or:  y = a | op_b;
			exec_pkg::alu_xor: y = a ^ op_b;
			exec_pkg::alu_slt: y = {{(exec_pkg::xlen-1){1'b0}}, lt};
			exec_pkg::alu_lui: begin
				// Immediate lands in the top 13 bits
				y = {op_b[exec_pkg::imm_w-1:0], {(exec_pkg::xlen - exec_pkg::imm_w){1'b0}}};
			end
			default: y = '0;
		endcase
	end

endmodule

// ==== src/exec_sequencer.sv ====
// Four-phase handshake FSM with instruction latch, write-back timing and result register
`timescale 1ns/1ns

module exec_sequencer (
	input  logic clk,
	input  logic rst,
	input  logic instr_req,
	input  logic [exec_pkg::xlen-1:0] instr,
	output logic instr_ack,
	output logic [exec_pkg::xlen-1:0] cur_instr,
	input  logic [exec_pkg::reg_addr_w-1:0] rd_addr,
	input  logic legal,
	input  logic [exec_pkg::xlen-1:0] alu_y,
	output logic [exec_pkg::reg_addr_w-1:0] waddr,
	output logic [exec_pkg::xlen-1:0] wdata,
	output logic we,
	output logic [exec_pkg::xlen-1:0] result
);

	typedef enum logic [1:0] {
		st_idle,
		st_exec,
		st_ack
	} state_t;

	state_t state;
	logic accept;

	assign accept = (state == st_idle) && instr_req && !instr_ack;

	// Write port is live only during execute
	assign we    = (state == st_exec) && legal;
	assign waddr = rd_addr;
	assign wdata = alu_y;

	always_ff @(posedge clk) begin
		if (accept) begin
			cur_instr <= instr;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state     <= st_idle;
			instr_ack <= 1'b0;
			result    <= '0;
		end else begin
			case (state)
				st_idle: begin
					if (accept) begin
						state <= st_exec;
					end
				end
				st_exec: begin
					result    <= legal ? alu_y : '0;   // Illegal opcode gives zero
					instr_ack <= 1'b1;
					state     <= st_ack;
				end
				st_ack: begin
					// Hold here until the agent drops its request
					if (!instr_req) begin
						instr_ack <= 1'b0;
						state     <= st_idle;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

endmodule

// ==== src/exec_top.sv ====
// Execute engine top level joining sequencer, decoder, ALU and register file
`timescale 1ns/1ns

module exec_top (
	input  logic clk,
	input  logic rst,
	input  logic instr_req,
	input  logic [exec_pkg::xlen-1:0] instr,
	output logic instr_ack,
	output logic [exec_pkg::xlen-1:0] result,
	input  logic [exec_pkg::reg_addr_w-1:0] which_reg,
	output logic [exec_pkg::xlen-1:0] reg_content
);

	logic [exec_pkg::xlen-1:0] cur_instr;
	logic [exec_pkg::reg_addr_w-1:0] rs_addr;
	logic [exec_pkg::reg_addr_w-1:0] rt_addr;
	logic [exec_pkg::reg_addr_w-1:0] rd_addr;
	logic [exec_pkg::alu_op_w-1:0] alu_op;
	logic use_imm;
	logic legal;
	logic [exec_pkg::xlen-1:0] imm_ext;
	logic [exec_pkg::xlen-1:0] rdata_a;
	logic [exec_pkg::xlen-1:0] rdata_b;
	logic [exec_pkg::xlen-1:0] alu_y;
	logic [exec_pkg::reg_addr_w-1:0] waddr;
	logic [exec_pkg::xlen-1:0] wdata;
	logic we;

	exec_sequencer seq_i (
		.clk(clk), .rst(rst), .instr_req(instr_req), .instr(instr),
		.instr_ack(instr_ack), .cur_instr(cur_instr), .rd_addr(rd_addr),
		.legal(legal), .alu_y(alu_y), .waddr(waddr), .wdata(wdata),
		.we(we), .result(result)
	);

	instr_decoder dec_i (
		.instr(cur_instr), .rs_addr(rs_addr), .rt_addr(rt_addr),
		.rd_addr(rd_addr), .alu_op(alu_op), .use_imm(use_imm),
		.legal(legal), .imm_ext(imm_ext)
	);

	alu alu_i (
		.a(rdata_a), .b(rdata_b), .imm_ext(imm_ext), .use_imm(use_imm),
		.alu_op(alu_op), .y(alu_y)
	);

	regfile rf_i (
		.clk(clk), .rst(rst), .raddr_a(rs_addr), .raddr_b(rt_addr),
		.waddr(waddr), .wdata(wdata), .we(we), .rdata_a(rdata_a),
		.rdata_b(rdata_b), .which_reg(which_reg), .reg_content(reg_content)
	);

endmodule

// ==== tb/exec_chk.sv ====
// Handshake and register-zero assertions for exec_top
`timescale 1ns/1ns

module exec_chk (
	input logic clk,
	input logic rst,
	input logic instr_req,
	input logic instr_ack,
	input logic [exec_pkg::reg_addr_w-1:0] which_reg,
	input logic [exec_pkg::xlen-1:0] reg_content
);

	// Ack only answers a request that was present on the edge it rose
	ack_needs_req: assert property (
		@(posedge clk) disable iff (rst) $rose(instr_ack) |-> $past(instr_req)
	) else $error("instr_ack rose without instr_req");

	ack_holds: assert property (
		@(posedge clk) disable iff (rst) (instr_ack && instr_req) |=> instr_ack
	) else $error("instr_ack fell while instr_req was high");

	// Register 0 and the unimplemented upper half
	zero_regs: assert property (
		@(posedge clk) disable iff (rst)
		(which_reg == '0 || which_reg[exec_pkg::reg_addr_w-1]) |-> reg_content == '0
	) else $error("reg_content not zero for which_reg %0d", which_reg);

endmodule

// ==== tb/exec_tb.sv ====
// Testbench for exec_top with random instructions, register model, handshake checks and watchdog
`timescale 1ns/1ns

module exec_tb;

	localparam int seed        = 32'hd2b0;
	localparam int num_instr   = 300;
	localparam int clk_period  = 10;
	localparam int max_wait    = 10;   // Cycles allowed for each handshake phase
	localparam int watchdog_ns = (num_instr * 12 + 1000) * clk_period;

	logic clk;
	logic rst;
	logic instr_req;
	logic [exec_pkg::xlen-1:0] instr;
	logic instr_ack;
	logic [exec_pkg::xlen-1:0] result;
	logic [exec_pkg::reg_addr_w-1:0] which_reg;
	logic [exec_pkg::xlen-1:0] reg_content;

	logic [exec_pkg::xlen-1:0] model_regs [0:15];
	int errors;

	exec_top dut_i (
		.clk(clk), .rst(rst), .instr_req(instr_req), .instr(instr),
		.instr_ack(instr_ack), .result(result), .which_reg(which_reg),
		.reg_content(reg_content)
	);

	bind exec_top exec_chk chk_i (
		.clk(clk), .rst(rst), .instr_req(instr_req), .instr_ack(instr_ack),
		.which_reg(which_reg), .reg_content(reg_content)
	);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	task automatic compare_val(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp);
			errors++;
		end
	endtask

	// Register 0 and addresses 16 to 31 read as zero
	function automatic logic [31:0] model_read(input logic [4:0] addr);
		return (addr != 5'd0 && !addr[4]) ? model_regs[addr[3:0]] : 32'd0;
	endfunction

	function automatic logic [31:0] model_exec(input logic [31:0] ins);
		logic [3:0] op;
		logic [31:0] a;
		logic [31:0] b;
		logic [12:0] imm;
		logic [31:0] y;
		op  = ins[exec_pkg::op_hi:exec_pkg::op_lo];
		a   = model_read(ins[exec_pkg::rs_hi:exec_pkg::rs_lo]);
		b   = model_read(ins[exec_pkg::rt_hi:exec_pkg::rt_lo]);
		imm = ins[exec_pkg::imm_hi:exec_pkg::imm_lo];
		case (op)
			exec_pkg::op_add:  y = a + b;
			exec_pkg::op_sub:  y = a - b;
			exec_pkg::op_and:  y = a & b;
			exec_pkg::op_or:   y = a | b;
			exec_pkg::op_xor:  y = a ^ b;
			exec_pkg::op_slt:  y = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			exec_pkg::op_addi: y = a + {{19{imm[12]}}, imm};
			exec_pkg::op_lui:  y = {imm, 19'd0};
			default:           y = 32'd0;   // Illegal opcode
		endcase
		return y;
	endfunction

	// One in four register fields lands in the unimplemented range
	function automatic logic [4:0] pick_reg();
		if ($urandom_range(0, 3) == 0) begin
			return 5'($urandom_range(16, 31));
		end
		return 5'($urandom_range(0, 15));
	endfunction

	function automatic logic [31:0] make_instr(input logic [4:0] prev_rd);
		logic [3:0] op;
		logic [4:0] rs;
		if ($urandom_range(0, 4) == 0) begin
			op = 4'($urandom_range(8, 15));
		end else begin
			op = 4'($urandom_range(0, 7));
		end
		rs = ($urandom_range(0, 2) == 0) ? prev_rd : pick_reg();   // Dependent chain
		return {op, pick_reg(), rs, pick_reg(), 13'($urandom)};
	endfunction

	// Called on a falling edge, returns on a falling edge
	task automatic scan_regs();
		which_reg = 5'd0;
		for (int i = 0; i < 32; i++) begin
			@(negedge clk);
			compare_val($sformatf("reg_content[%0d]", i), reg_content, model_read(5'(i)));
			which_reg = 5'(i + 1);
		end
	endtask

	task automatic run_instr(input logic [31:0] ins);
		logic [31:0] exp_y;
		logic [4:0] rd;
		int cycles;
		int hold;
		exp_y     = model_exec(ins);
		rd        = ins[exec_pkg::rd_hi:exec_pkg::rd_lo];
		instr     = ins;
		instr_req = 1'b1;
		cycles    = 0;
		do begin
			@(negedge clk);
			cycles++;
		end while (!instr_ack && cycles < max_wait);
		if (!instr_ack) begin
			$display("instr_ack did not rise within %0d cycles of the request", max_wait);
			errors++;
		end else begin
			compare_val("ack_latency", 32'(cycles), 32'd2);
			compare_val("result", result, exp_y);
		end
		// Only opcodes 0 to 7 with rd 1 to 15 write
		if (!ins[exec_pkg::op_hi] && rd != 5'd0 && !rd[4]) begin
			model_regs[rd[3:0]] = exp_y;
		end
		hold = $urandom_range(0, 5);
		repeat (hold) begin
			@(negedge clk);
			compare_val("instr_ack", 32'(instr_ack), 32'd1);
		end
		instr_req = 1'b0;
		cycles    = 0;
		do begin
			@(negedge clk);
			cycles++;
		end while (instr_ack && cycles < max_wait);
		if (instr_ack) begin
			$display("instr_ack stayed high after the request was dropped");
			errors++;
		end else begin
			compare_val("ack_release", 32'(cycles), 32'd1);
		end
		which_reg = rd;
		@(negedge clk);
		compare_val("reg_content", reg_content, model_read(rd));
	endtask

	initial begin
		logic [31:0] ins;
		logic [4:0] prev_rd;
		rst       = 1'b1;
		instr_req = 1'b0;
		instr     = '0;
		which_reg = '0;
		errors    = 0;
		prev_rd   = 5'd0;
		for (int i = 0; i < 16; i++) begin
			model_regs[i] = 32'd0;
		end
		void'($urandom(seed));
		repeat (8) @(negedge clk);
		rst = 1'b0;
		compare_val("instr_ack", 32'(instr_ack), 32'd0);
		compare_val("result", result, 32'd0);
		scan_regs();
		for (int n = 0; n < num_instr; n++) begin
			ins     = make_instr(prev_rd);
			prev_rd = ins[exec_pkg::rd_hi:exec_pkg::rd_lo];
			run_instr(ins);
			if (n % 25 == 24) begin
				scan_regs();
			end
		end
		scan_regs();
		$display("Errors: %0d", errors);
		if (errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

	initial begin
		#(watchdog_ns);
		$display("Run hung: the watchdog expired before all instructions completed");
		$display("** FAIL **");
		$finish;
	end

endmodule

// ==== verilog.f ====
src/exec_pkg.sv
src/regfile.sv
src/instr_decoder.sv
src/alu.sv
src/exec_sequencer.sv
src/exec_top.sv
tb/exec_chk.sv
tb/exec_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run the testbench, then scan the log for the fail message
verilator --binary --timing --assert --top-module exec_tb -f verilog.f -o exec_sim \
	&& ./obj_dir/exec_sim > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }
cat sim.log
grep -q "\*\* FAIL \*\*" sim.log && { echo "test failed"; exit 1; } || echo "test passed"
